// File: src/mc_pkg.sv
package mc_pkg;

    // element and line geometry
    localparam int ELEM_BITS      = 32;
    localparam int ELEMS_PER_LINE = 4;
    localparam int ELEM_BYTES     = 4;

    // index and address widths
    localparam int INDEX_BITS = 16;
    localparam int ADDR_BITS  = 32;

    // byte address into shared memory
    typedef logic [ADDR_BITS-1:0] addr_t;

    // row or column index of matrix C
    typedef logic [INDEX_BITS-1:0] index_t;

    // one matrix element
    typedef logic [ELEM_BITS-1:0] elem_t;

    // one cacheline, element k in slice k from the lsb
    typedef logic [ELEMS_PER_LINE*ELEM_BITS-1:0] line_t;

    // valid elements in one read, 1 to ELEMS_PER_LINE
    typedef logic [$clog2(ELEMS_PER_LINE+1)-1:0] count_t;

    // job word, ii on top, then jj, then the element
    typedef logic [2*INDEX_BITS+ELEM_BITS-1:0] job_t;

    // tile walker states
    typedef enum logic [2:0] {
        WALK_IDLE,
        WALK_ISSUE,
        WALK_WAIT,
        WALK_NEXT,
        WALK_DONE
    } walk_state_t;

endpackage

// File: src/mc_if.sv
// clipped tile bounds, bounds stage to walker
interface tile_if import mc_pkg::*; ();

    logic   tile_valid;
    addr_t  base;
    index_t size_n;
    index_t start_ii;
    index_t start_jj;
    // exclusive ends
    index_t end_ii;
    index_t end_jj;

    modport bounds (
        output tile_valid, base, size_n, start_ii, start_jj, end_ii, end_jj
    );

    modport walker (
        input tile_valid, base, size_n, start_ii, start_jj, end_ii, end_jj
    );

endinterface

// one outstanding line, walker to unpacker and back
interface line_if import mc_pkg::*; ();

    logic   line_start;
    index_t line_ii;
    index_t line_jj;
    count_t line_count;
    logic   line_done;

    modport walker (
        output line_start, line_ii, line_jj, line_count,
        input  line_done
    );

    modport unpacker (
        input  line_start, line_ii, line_jj, line_count,
        output line_done
    );

endinterface

// File: src/mc_tile_bounds.sv
module mc_tile_bounds import mc_pkg::*; (
    input  logic   clock,
    input  logic   rstn,
    input  logic   cfg_valid,
    input  addr_t  cfg_base,
    input  index_t cfg_size_n,
    input  index_t cfg_size_tile,
    input  index_t cfg_start_ii,
    input  index_t cfg_start_jj,
    input  logic   cfg_accept,
    tile_if.bounds tile
);

    logic   take;
    logic   limit_valid;
    index_t limit_ii;
    index_t limit_jj;

    function automatic index_t min_index(input index_t a, input index_t b);
        return (a < b) ? a : b;
    endfunction

    // new configuration only while the walker is idle or finished
    assign take = cfg_valid && cfg_accept;

    // step one registers the limit, step two the clamped end
    always_ff @(posedge clock or negedge rstn) begin
        if (!rstn) begin
            limit_valid     <= 1'b0;
            tile.tile_valid <= 1'b0;
        end else begin
            limit_valid     <= take;
            tile.tile_valid <= limit_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            tile.base     <= cfg_base;
            tile.size_n   <= cfg_size_n;
            tile.start_ii <= cfg_start_ii;
            tile.start_jj <= cfg_start_jj;
            limit_ii      <= cfg_start_ii + cfg_size_tile;
            limit_jj      <= cfg_start_jj + cfg_size_tile;
        end
        // clip to the matrix edge
        if (limit_valid) begin
            tile.end_ii <= min_index(limit_ii, tile.size_n);
            tile.end_jj <= min_index(limit_jj, tile.size_n);
        end
    end

endmodule

// File: src/mc_tile_walker.sv
module mc_tile_walker import mc_pkg::*; (
    input  logic   clock,
    input  logic   rstn,
    tile_if.walker tile,
    line_if.walker line,
    output logic   read_cmd_request,
    output addr_t  read_cmd_address,
    output count_t read_cmd_size,
    input  logic   read_cmd_grant,
    output logic   cfg_accept,
    output logic   tile_done
);

    walk_state_t state;
    walk_state_t next_state;
    index_t      ii;
    index_t      jj;
    index_t      cols_left;
    count_t      chunk;
    addr_t       offset;
    logic        tile_empty;
    logic        row_end;
    logic        idle_like;

////////////////////////////////////////////////////////////////////////////
// chunk geometry
////////////////////////////////////////////////////////////////////////////

    assign cols_left  = tile.end_jj - jj;
    assign row_end    = (cols_left <= index_t'(ELEMS_PER_LINE));
    assign tile_empty = (tile.start_ii >= tile.end_ii) || (tile.start_jj >= tile.end_jj);

    // partial last chunk of a row
    always_comb begin
        if (cols_left >= index_t'(ELEMS_PER_LINE)) begin
            chunk = count_t'(ELEMS_PER_LINE);
        end else begin
            chunk = count_t'(cols_left);
        end
    end

    // element offset ii * size_n + jj, scaled to bytes
    assign offset = (addr_t'(ii) * addr_t'(tile.size_n) + addr_t'(jj))
                  * addr_t'(ELEM_BYTES);

    assign read_cmd_request = (state == WALK_ISSUE);
    assign read_cmd_address = tile.base + offset;
    assign read_cmd_size    = chunk;

    assign idle_like  = (state == WALK_IDLE) || (state == WALK_DONE);
    assign cfg_accept = idle_like;
    assign tile_done  = (state == WALK_DONE);

    // counters hold still from grant to line_done
    assign line.line_ii    = ii;
    assign line.line_jj    = jj;
    assign line.line_count = chunk;

////////////////////////////////////////////////////////////////////////////
// walk FSM
////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rstn) begin
        if (!rstn) begin
            state <= WALK_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            WALK_IDLE, WALK_DONE: begin
                if (tile.tile_valid) begin
                    next_state = tile_empty ? WALK_DONE : WALK_ISSUE;
                end
            end
            WALK_ISSUE: begin
                if (read_cmd_grant) begin
                    next_state = WALK_WAIT;
                end
            end
            WALK_WAIT: begin
                if (line.line_done) begin
                    next_state = WALK_NEXT;
                end
            end
            WALK_NEXT: begin
                // counters already advanced
                next_state = (ii >= tile.end_ii) ? WALK_DONE : WALK_ISSUE;
            end
            default: begin
                next_state = WALK_IDLE;
            end
        endcase
    end

    // row and column counters
    always_ff @(posedge clock or negedge rstn) begin
        if (!rstn) begin
            ii <= '0;
            jj <= '0;
        end else begin
            if (idle_like && tile.tile_valid) begin
                ii <= tile.start_ii;
                jj <= tile.start_jj;
            end else if ((state == WALK_WAIT) && line.line_done) begin
                if (row_end) begin
                    ii <= ii + 1'b1;
                    jj <= tile.start_jj;
                end else begin
                    jj <= jj + index_t'(chunk);
                end
            end
        end
    end

    // one line per granted command
    always_ff @(posedge clock or negedge rstn) begin
        if (!rstn) begin
            line.line_start <= 1'b0;
        end else begin
            line.line_start <= (state == WALK_ISSUE) && read_cmd_grant;
        end
    end

endmodule

// File: src/mc_line_unpacker.sv
module mc_line_unpacker import mc_pkg::*; (
    input  logic     clock,
    input  logic     rstn,
    input  logic     read_data_valid,
    input  line_t    read_data,
    line_if.unpacker line,
    output logic     push,
    output job_t     data,
    input  logic     full
);

    logic   pending;
    logic   shifting;
    logic   accept;
    logic   last;
    count_t count_r;
    count_t left;
    index_t ii_r;
    index_t jj_r;
    line_t  line_r;

    // data may land in the same cycle as line_start
    assign accept = read_data_valid && (pending || line.line_start);
    assign push   = shifting && !full;
    assign last   = (left == count_t'(1));
    assign data   = {ii_r, jj_r, elem_t'(line_r[ELEM_BITS-1:0])};

////////////////////////////////////////////////////////////////////////////
// line tracking
////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge rstn) begin
        if (!rstn) begin
            pending        <= 1'b0;
            shifting       <= 1'b0;
            left           <= '0;
            line.line_done <= 1'b0;
        end else begin
            line.line_done <= push && last;
            if (accept) begin
                pending  <= 1'b0;
                shifting <= 1'b1;
                left     <= line.line_start ? line.line_count : count_r;
            end else begin
                if (line.line_start) begin
                    pending <= 1'b1;
                end
                if (push) begin
                    left <= left - 1'b1;
                    if (last) begin
                        shifting <= 1'b0;
                    end
                end
            end
        end
    end

////////////////////////////////////////////////////////////////////////////
// element shifter
////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (line.line_start) begin
            ii_r    <= line.line_ii;
            jj_r    <= line.line_jj;
            count_r <= line.line_count;
        end
        if (accept) begin
            line_r <= read_data;
        end else if (push) begin
            // next element drops into the low slice
            line_r <= line_r >> ELEM_BITS;
            jj_r   <= jj_r + 1'b1;
        end
    end

endmodule

// File: src/mc_fifo.sv
module mc_fifo #(
    parameter int WIDTH = 64,
    parameter int DEPTH = 8
) (
    input  logic             clock,
    input  logic             rstn,
    input  logic             push,
    input  logic [WIDTH-1:0] data_in,
    output logic             full,
    input  logic             pop,
    output logic             valid,
    output logic [WIDTH-1:0] data_out
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0]    mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                do_push;
    logic                do_pop;

    assign full     = (count == (PTR_BITS+1)'(DEPTH));
    assign valid    = (count != '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && valid;
    // show-ahead head
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clock or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            // occupancy
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: src/mc_top.sv
module mc_top import mc_pkg::*; #(
    parameter int JOB_DEPTH = 8
) (
    input  logic   clock,
    input  logic   rstn,
    input  logic   cfg_valid,
    input  addr_t  cfg_base,
    input  index_t cfg_size_n,
    input  index_t cfg_size_tile,
    input  index_t cfg_start_ii,
    input  index_t cfg_start_jj,
    output logic   read_cmd_request,
    output addr_t  read_cmd_address,
    output count_t read_cmd_size,
    input  logic   read_cmd_grant,
    input  logic   read_data_valid,
    input  line_t  read_data,
    output logic   job_valid,
    output index_t job_ii,
    output index_t job_jj,
    output elem_t  job_data,
    input  logic   job_request,
    output logic   tile_done
);

    logic cfg_accept;
    logic job_push;
    logic job_full;
    job_t job_in;
    job_t job_head;

    tile_if tile ();
    line_if line ();

////////////////////////////////////////////////////////////////////////////
// input side and walk
////////////////////////////////////////////////////////////////////////////

    mc_tile_bounds bounds_inst (
        .clock        (clock),
        .rstn         (rstn),
        .cfg_valid    (cfg_valid),
        .cfg_base     (cfg_base),
        .cfg_size_n   (cfg_size_n),
        .cfg_size_tile(cfg_size_tile),
        .cfg_start_ii (cfg_start_ii),
        .cfg_start_jj (cfg_start_jj),
        .cfg_accept   (cfg_accept),
        .tile         (tile)
    );

    mc_tile_walker walker_inst (
        .clock           (clock),
        .rstn            (rstn),
        .tile            (tile),
        .line            (line),
        .read_cmd_request(read_cmd_request),
        .read_cmd_address(read_cmd_address),
        .read_cmd_size   (read_cmd_size),
        .read_cmd_grant  (read_cmd_grant),
        .cfg_accept      (cfg_accept),
        .tile_done       (tile_done)
    );

////////////////////////////////////////////////////////////////////////////
// output side
////////////////////////////////////////////////////////////////////////////

    mc_line_unpacker unpacker_inst (
        .clock          (clock),
        .rstn           (rstn),
        .read_data_valid(read_data_valid),
        .read_data      (read_data),
        .line           (line),
        .push           (job_push),
        .data           (job_in),
        .full           (job_full)
    );

    mc_fifo #(
        .WIDTH($bits(job_t)),
        .DEPTH(JOB_DEPTH)
    ) job_fifo_inst (
        .clock   (clock),
        .rstn    (rstn),
        .push    (job_push),
        .data_in (job_in),
        .full    (job_full),
        .pop     (job_request),
        .valid   (job_valid),
        .data_out(job_head)
    );

    // split the head job into its fields
    assign {job_ii, job_jj, job_data} = job_head;

endmodule

// File: test/mc_props.sv
module mc_props import mc_pkg::*; (
    input logic   clock,
    input logic   rstn,
    input logic   cfg_valid,
    input addr_t  cfg_base,
    input index_t cfg_size_n,
    input index_t cfg_size_tile,
    input index_t cfg_start_ii,
    input index_t cfg_start_jj,
    input logic   read_cmd_request,
    input addr_t  read_cmd_address,
    input count_t read_cmd_size,
    input logic   read_cmd_grant,
    input logic   job_valid,
    input index_t job_ii,
    input index_t job_jj,
    input elem_t  job_data,
    input logic   job_request,
    input logic   tile_done
);

    logic  seen_cfg;
    logic  pop;
    int    size_n;
    int    start_ii;
    int    start_jj;
    int    tile_sz;
    int    end_ii;
    int    end_jj;
    int    elem;
    int    cmd_row;
    int    cmd_col;
    int    cmd_span;
    int    exp_ii;
    int    exp_jj;
    addr_t job_addr;

    // configuration as plain integers
    assign size_n   = int'(cfg_size_n);
    assign start_ii = int'(cfg_start_ii);
    assign start_jj = int'(cfg_start_jj);
    assign tile_sz  = int'(cfg_size_tile);

    // clipped ends from the configuration ports
    assign end_ii   = (start_ii + tile_sz < size_n) ? start_ii + tile_sz : size_n;
    assign end_jj   = (start_jj + tile_sz < size_n) ? start_jj + tile_sz : size_n;
    assign elem     = int'((read_cmd_address - cfg_base) / ELEM_BYTES);
    assign cmd_row  = (size_n != 0) ? elem / size_n : 0;
    assign cmd_col  = (size_n != 0) ? elem % size_n : 0;
    assign cmd_span = (end_jj - cmd_col < ELEMS_PER_LINE) ? end_jj - cmd_col : ELEMS_PER_LINE;
    assign pop      = job_valid && job_request;

    // byte address of element ii, jj
    assign job_addr = cfg_base
                    + addr_t'((int'(job_ii) * size_n + int'(job_jj)) * ELEM_BYTES);

    always_ff @(posedge clock or negedge rstn) begin
        if (!rstn) begin
            seen_cfg <= 1'b0;
            exp_ii   <= 0;
            exp_jj   <= 0;
        end else if (cfg_valid) begin
            seen_cfg <= 1'b1;
            exp_ii   <= start_ii;
            exp_jj   <= start_jj;
        end else if (pop) begin
            // row-major walk of the clipped tile
            if (exp_jj + 1 >= end_jj) begin
                exp_ii <= exp_ii + 1;
                exp_jj <= start_jj;
            end else begin
                exp_jj <= exp_jj + 1;
            end
        end
    end

    quiet_after_reset: assert property (@(posedge clock) disable iff (!rstn)
        !seen_cfg |-> !read_cmd_request && !job_valid && !tile_done)
        else $error("outputs active before the first configuration");

    cmd_held: assert property (@(posedge clock) disable iff (!rstn)
        read_cmd_request && !read_cmd_grant |=>
            $stable(read_cmd_address) && $stable(read_cmd_size))
        else $error("read command changed while waiting for grant");

    cmd_in_tile: assert property (@(posedge clock) disable iff (!rstn)
        read_cmd_request |-> cmd_row >= start_ii && cmd_row < end_ii
            && cmd_col >= start_jj && cmd_col < end_jj
            && int'(read_cmd_size) == cmd_span)
        else $error("read command outside the clipped tile or wrong size");

    job_value: assert property (@(posedge clock) disable iff (!rstn)
        pop |-> job_data == job_addr)
        else $error("job value does not match its ii and jj");

    job_order: assert property (@(posedge clock) disable iff (!rstn)
        pop |-> int'(job_ii) == exp_ii && int'(job_jj) == exp_jj)
        else $error("job out of row-major order");

endmodule

bind mc_top mc_props props_inst (
    .clock(clock), .rstn(rstn), .cfg_valid(cfg_valid), .cfg_base(cfg_base),
    .cfg_size_n(cfg_size_n), .cfg_size_tile(cfg_size_tile),
    .cfg_start_ii(cfg_start_ii), .cfg_start_jj(cfg_start_jj),
    .read_cmd_request(read_cmd_request), .read_cmd_address(read_cmd_address),
    .read_cmd_size(read_cmd_size), .read_cmd_grant(read_cmd_grant),
    .job_valid(job_valid), .job_ii(job_ii), .job_jj(job_jj), .job_data(job_data),
    .job_request(job_request), .tile_done(tile_done)
);

// File: test/mc_tb.sv
module mc_tb import mc_pkg::*; ();

    localparam int SEED_INIT    = 93863;
    localparam int MAX_CYCLES   = 4000;
    localparam int NUM_TILES    = 3;
    localparam int SIZE_N       = 10;
    localparam int BASE         = 32'h1000;
    localparam int STALL_CYCLES = 80;

    // tile list, start row, start column, tile size
    localparam int TILE_II [NUM_TILES] = '{0, 6, 10};
    localparam int TILE_JJ [NUM_TILES] = '{0, 7, 0};
    localparam int TILE_SZ [NUM_TILES] = '{6, 6, 4};

    logic   clock;
    logic   rstn;
    logic   cfg_valid;
    addr_t  cfg_base;
    index_t cfg_size_n;
    index_t cfg_size_tile;
    index_t cfg_start_ii;
    index_t cfg_start_jj;
    logic   read_cmd_request;
    addr_t  read_cmd_address;
    count_t read_cmd_size;
    logic   read_cmd_grant;
    logic   read_data_valid;
    line_t  read_data;
    logic   job_valid;
    index_t job_ii;
    index_t job_jj;
    elem_t  job_data;
    logic   job_request;
    logic   tile_done;

    integer seed;
    int     errors;
    int     timeouts;
    int     cycles;
    int     popped;
    int     grant_wait;
    int     data_wait;
    int     stall;
    addr_t  cmd_addr;
    count_t cmd_size;

    mc_top #(.JOB_DEPTH(8)) mc_top_inst (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // memory returns element k as the address of column jj + k
    function automatic line_t build_line(input addr_t addr, input count_t size);
        line_t l;
        for (int k = 0; k < ELEMS_PER_LINE; k++) begin
            if (k < int'(size)) begin
                l[k*ELEM_BITS +: ELEM_BITS] = addr + k * ELEM_BYTES;
            end else begin
                l[k*ELEM_BITS +: ELEM_BITS] = '1;
            end
        end
        return l;
    endfunction

    function automatic int clipped_span(input int start, input int tile);
        int stop;
        stop = (start + tile < SIZE_N) ? start + tile : SIZE_N;
        return (stop > start) ? stop - start : 0;
    endfunction

    // grant, read data and consumer side, all on the falling edge
    always @(negedge clock) begin
        read_data_valid = 1'b0;
        if (data_wait > 0) begin
            data_wait = data_wait - 1;
            if (data_wait == 0) begin
                read_data_valid = 1'b1;
                read_data       = build_line(cmd_addr, cmd_size);
            end
        end
        if (read_cmd_grant) begin
            read_cmd_grant = 1'b0;
        end else if (read_cmd_request) begin
            if (grant_wait == 0) begin
                read_cmd_grant = 1'b1;
                cmd_addr       = read_cmd_address;
                cmd_size       = read_cmd_size;
                data_wait      = 1 + ($unsigned($random(seed)) % 4);
                grant_wait     = $unsigned($random(seed)) % 4;
            end else begin
                grant_wait = grant_wait - 1;
            end
        end
        // consumer holds off at the start of a tile so the job queue fills
        if (stall > 0) begin
            stall       = stall - 1;
            job_request = 1'b0;
        end else begin
            job_request = 1'($random(seed));
        end
        // pop happens at the coming rising edge
        if (job_valid && job_request) begin
            popped = popped + 1;
        end
    end

    always @(posedge clock) begin
        if (cfg_valid) begin
            stall = STALL_CYCLES;
        end
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            timeouts = timeouts + 1;
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("errors: %0d, timeouts: %0d", errors, timeouts);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic run_tile(input int t);
        int area;
        area = clipped_span(TILE_II[t], TILE_SZ[t]) * clipped_span(TILE_JJ[t], TILE_SZ[t]);
        @(negedge clock);
        popped        = 0;
        cfg_base      = BASE;
        cfg_size_n    = index_t'(SIZE_N);
        cfg_size_tile = index_t'(TILE_SZ[t]);
        cfg_start_ii  = index_t'(TILE_II[t]);
        cfg_start_jj  = index_t'(TILE_JJ[t]);
        cfg_valid     = 1'b1;
        @(negedge clock);
        cfg_valid = 1'b0;
        // let the new bounds reach the walker
        repeat (4) @(negedge clock);
        while (!(tile_done && !job_valid)) begin
            @(negedge clock);
        end
        if (popped != area) begin
            errors = errors + 1;
            $display("error at %0t: tile %0d popped %0d jobs, expected %0d",
                     $time, t, popped, area);
        end
    endtask

    initial begin
        seed            = SEED_INIT;
        errors          = 0;
        timeouts        = 0;
        cycles          = 0;
        popped          = 0;
        grant_wait      = 0;
        data_wait       = 0;
        stall           = 0;
        rstn            = 1'b0;
        cfg_valid       = 1'b0;
        cfg_base        = '0;
        cfg_size_n      = '0;
        cfg_size_tile   = '0;
        cfg_start_ii    = '0;
        cfg_start_jj    = '0;
        read_cmd_grant  = 1'b0;
        read_data_valid = 1'b0;
        read_data       = '0;
        job_request     = 1'b0;
        repeat (3) @(negedge clock);
        rstn = 1'b1;
        for (int t = 0; t < NUM_TILES; t++) begin
            run_tile(t);
        end
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
src/mc_pkg.sv
src/mc_if.sv
src/mc_tile_bounds.sv
src/mc_tile_walker.sv
src/mc_line_unpacker.sv
src/mc_fifo.sv
src/mc_top.sv
test/mc_props.sv
test/mc_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module mc_tb -f files.f
out=$(./obj_dir/Vmc_tb || true)
echo "$out"
echo "$out" | grep -q "Simulation PASSED"
echo "run.sh: pass"
